// ==== src/mipsPkg.sv ====
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [regAddrWidth-1:0] regAddrT;

    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddiu = 6'h09,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opLui   = 6'h0f,
        opLw    = 6'h23,
        opSw    = 6'h2b,
        opHalt  = 6'h3f
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } funcE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluLui
    } aluOpE;

    typedef enum logic [1:0] {
        fwdReg = 2'd0,  // value read in ID
        fwdMem = 2'd1,  // EX/MEM ALU result
        fwdWb  = 2'd2   // write-back bus
    } fwdSelE;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  mem2Reg;
        logic  aluSrcImm;
        aluOpE aluOp;
        logic  halt;
    } ctrlT;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                 ctrl;
        regAddrT              rs;
        regAddrT              rt;
        regAddrT              dest;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] imm;
        logic [4:0]           shamt;
    } idExT;

    typedef struct packed {
        ctrlT                 ctrl;
        regAddrT              dest;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic                 regWrite;
        logic                 mem2Reg;
        logic                 halt;
        regAddrT              dest;
        logic [dataWidth-1:0] loadData;
        logic [dataWidth-1:0] aluResult;
    } memWbT;

    typedef struct packed {
        logic                 we;
        regAddrT              dest;
        logic [dataWidth-1:0] data;
    } wbT;

endpackage

// ==== src/ifStage.sv ====
module ifStage
    import mipsPkg::*;
#(
    parameter int imemDepth = 256
) (
    input  logic                 clk,
    input  logic                 i_rstN,
    input  logic                 i_halt,
    input  logic                 i_stall,
    input  logic                 i_haltSeen,
    input  logic                 i_imemWe,
    input  logic [dataWidth-1:0] i_imemAddr,
    input  logic [dataWidth-1:0] i_imemData,
    input  logic                 i_redirect,
    input  logic [dataWidth-1:0] i_target,
    output ifIdT                 o_ifId
);

    localparam int imemAw = $clog2(imemDepth);

    logic [dataWidth-1:0] imem [imemDepth];
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] fetchWord;

    assign fetchWord = imem[pc[2 +: imemAw]];  // byte pc to word index

    // loader only writes while the core is halted
    always_ff @(posedge clk) begin
        if (i_halt && i_imemWe) begin
            imem[i_imemAddr[imemAw-1:0]] <= i_imemData;
        end
    end

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            pc     <= '0;
            o_ifId <= '0;
        end else if (!i_halt && !i_stall) begin
            if (i_haltSeen) begin
                o_ifId <= '0;  // nothing fetched past HALT
            end else if (i_redirect) begin
                pc     <= i_target;
                o_ifId <= '0;  // squash wrong-path fetch
            end else begin
                pc           <= pc + dataWidth'(4);
                o_ifId.valid <= 1'b1;
                o_ifId.pc    <= pc;
                o_ifId.instr <= fetchWord;
            end
        end
    end

endmodule

// ==== src/idStage.sv ====
module idStage
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 i_rstN,
    input  logic                 i_halt,
    input  logic                 i_stall,
    input  ifIdT                 i_ifId,
    input  wbT                   i_wb,
    input  regAddrT              i_dbgRegAddr,
    output idExT                 o_idEx,
    output logic                 o_redirect,
    output logic [dataWidth-1:0] o_target,
    output logic                 o_haltSeen,
    output logic [dataWidth-1:0] o_dbgRegData
);

    localparam int numRegs = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regFile [numRegs];
    opcodeE               opcode;
    funcE                 funct;
    regAddrT              rs;
    regAddrT              rt;
    regAddrT              rd;
    logic [dataWidth-1:0] immSext;
    logic [dataWidth-1:0] immZext;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    ctrlT                 ctrl;
    regAddrT              dest;
    logic                 useZext;
    logic                 isHalt;
    logic                 haltSeenQ;
    logic                 brTaken;

    assign opcode  = opcodeE'(i_ifId.instr[31:26]);
    assign funct   = funcE'(i_ifId.instr[5:0]);
    assign rs      = i_ifId.instr[25:21];
    assign rt      = i_ifId.instr[20:16];
    assign rd      = i_ifId.instr[15:11];
    assign immSext = {{(dataWidth-16){i_ifId.instr[15]}}, i_ifId.instr[15:0]};
    assign immZext = {{(dataWidth-16){1'b0}}, i_ifId.instr[15:0]};
    assign pcPlus4 = i_ifId.pc + dataWidth'(4);

    // r0 reads as zero, a write-back in this cycle is seen at once
    function automatic logic [dataWidth-1:0] readReg(regAddrT addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wb.we && i_wb.dest == addr) begin
            return i_wb.data;
        end
        return regFile[addr];
    endfunction

    always_comb begin
        rsData = readReg(rs);
        rtData = readReg(rt);
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        dest       = rt;
        useZext    = 1'b0;
        case (opcode)
            opRtype: begin
                dest          = rd;
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAddu:  ctrl.aluOp = aluAdd;
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnXor:   ctrl.aluOp = aluXor;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    fnSll:   ctrl.aluOp = aluSll;
                    fnSrl:   ctrl.aluOp = aluSrl;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opAndi, opOri: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = (opcode == opAndi) ? aluAnd : aluOr;
                useZext        = 1'b1;
            end
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluLui;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.mem2Reg   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opHalt:  ctrl.halt = 1'b1;
            default: ctrl = '0;  // branches, jumps and unknown opcodes
        endcase
        if (!i_ifId.valid) begin
            ctrl = '0;
        end
    end

    assign isHalt  = i_ifId.valid && opcode == opHalt;
    assign brTaken = (opcode == opBeq && rsData == rtData) ||
                     (opcode == opBne && rsData != rtData) ||
                     opcode == opJ;

    assign o_redirect   = i_ifId.valid && !i_stall && brTaken;
    assign o_target     = (opcode == opJ) ? {pcPlus4[31:28], i_ifId.instr[25:0], 2'b00}
                                          : pcPlus4 + {immSext[dataWidth-3:0], 2'b00};
    assign o_haltSeen   = haltSeenQ || isHalt;
    assign o_dbgRegData = regFile[i_dbgRegAddr];

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (i_wb.we && i_wb.dest != '0) begin
            regFile[i_wb.dest] <= i_wb.data;
        end
    end

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_idEx    <= '0;
            haltSeenQ <= 1'b0;
        end else if (!i_halt) begin
            if (i_stall || haltSeenQ) begin
                o_idEx <= '0;  // bubble
            end else begin
                o_idEx.ctrl  <= ctrl;
                o_idEx.rs    <= rs;
                o_idEx.rt    <= rt;
                o_idEx.dest  <= dest;
                o_idEx.opA   <= rsData;
                o_idEx.opB   <= rtData;
                o_idEx.imm   <= useZext ? immZext : immSext;
                o_idEx.shamt <= i_ifId.instr[10:6];
            end
            if (isHalt && !i_stall) begin
                haltSeenQ <= 1'b1;
            end
        end
    end

endmodule

// ==== src/exStage.sv ====
module exStage
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 i_rstN,
    input  logic                 i_halt,
    input  idExT                 i_idEx,
    input  fwdSelE               i_fwdA,
    input  fwdSelE               i_fwdB,
    input  logic [dataWidth-1:0] i_memFwd,
    input  wbT                   i_wb,
    output exMemT                o_exMem
);

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;

    function automatic logic [dataWidth-1:0] fwdMux(
        fwdSelE               sel,
        logic [dataWidth-1:0] regVal,
        logic [dataWidth-1:0] memVal,
        logic [dataWidth-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(i_fwdA, i_idEx.opA, i_memFwd, i_wb.data);
    assign regB = fwdMux(i_fwdB, i_idEx.opB, i_memFwd, i_wb.data);  // also the store data
    assign opB  = i_idEx.ctrl.aluSrcImm ? i_idEx.imm : regB;

    always_comb begin
        case (i_idEx.ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = dataWidth'($signed(opA) < $signed(opB));
            aluSll:  aluResult = opB << i_idEx.shamt;  // shifts act on rt
            aluSrl:  aluResult = opB >> i_idEx.shamt;
            aluLui:  aluResult = i_idEx.imm << 16;
            default: aluResult = opA + opB;
        endcase
    end

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_exMem <= '0;
        end else if (!i_halt) begin
            o_exMem.ctrl      <= i_idEx.ctrl;
            o_exMem.dest      <= i_idEx.dest;
            o_exMem.aluResult <= aluResult;
            o_exMem.storeData <= regB;
        end
    end

endmodule

// ==== src/memStage.sv ====
module memStage
    import mipsPkg::*;
#(
    parameter int dmemDepth = 256
) (
    input  logic                 clk,
    input  logic                 i_rstN,
    input  logic                 i_halt,
    input  exMemT                i_exMem,
    input  logic [dataWidth-1:0] i_dbgMemAddr,
    output wbT                   o_wb,
    output logic [dataWidth-1:0] o_dbgMemData,
    output logic                 o_end
);

    localparam int dmemAw = $clog2(dmemDepth);

    logic [dataWidth-1:0] dmem [dmemDepth];
    logic [dmemAw-1:0]    wordAddr;
    memWbT                memWb;
    logic                 endQ;

    assign wordAddr = i_exMem.aluResult[2 +: dmemAw];  // byte address, word aligned

    always_ff @(posedge clk) begin
        if (!i_halt && i_exMem.ctrl.memWrite) begin
            dmem[wordAddr] <= i_exMem.storeData;
        end
    end

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            memWb <= '0;
            endQ  <= 1'b0;
        end else if (!i_halt) begin
            memWb.regWrite  <= i_exMem.ctrl.regWrite;
            memWb.mem2Reg   <= i_exMem.ctrl.mem2Reg;
            memWb.halt      <= i_exMem.ctrl.halt;
            memWb.dest      <= i_exMem.dest;
            memWb.loadData  <= dmem[wordAddr];
            memWb.aluResult <= i_exMem.aluResult;
            endQ            <= endQ || memWb.halt;
        end
    end

    assign o_wb.we   = memWb.regWrite;
    assign o_wb.dest = memWb.dest;
    assign o_wb.data = memWb.mem2Reg ? memWb.loadData : memWb.aluResult;

    // high from the cycle HALT reaches MEM/WB, then held
    assign o_end = endQ || memWb.halt;

    assign o_dbgMemData = dmem[i_dbgMemAddr[dmemAw-1:0]];  // word address

endmodule

// ==== src/hazardUnit.sv ====
module hazardUnit
    import mipsPkg::*;
(
    input  ifIdT    i_ifId,
    input  idExT    i_idEx,
    input  exMemT   i_exMem,
    input  regAddrT i_wbDest,
    input  logic    i_wbWrite,
    output logic    o_stall,
    output fwdSelE  o_fwdA,
    output fwdSelE  o_fwdB
);

    opcodeE  opcode;
    regAddrT srcRs;
    regAddrT srcRt;
    logic    isBranch;
    logic    loadUse;
    logic    exBlock;
    logic    memBlock;

    function automatic logic hits(regAddrT dest, regAddrT a, regAddrT b);
        return dest != '0 && (dest == a || dest == b);
    endfunction

    function automatic fwdSelE pickFwd(regAddrT src, exMemT exMem, regAddrT wbDest,
                                       logic wbWrite);
        if (exMem.ctrl.regWrite && exMem.dest != '0 && exMem.dest == src) begin
            return fwdMem;  // youngest value wins
        end else if (wbWrite && wbDest != '0 && wbDest == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign opcode   = opcodeE'(i_ifId.instr[31:26]);
    assign srcRs    = i_ifId.instr[25:21];
    assign srcRt    = i_ifId.instr[20:16];
    assign isBranch = i_ifId.valid && (opcode == opBeq || opcode == opBne);

    assign loadUse  = i_ifId.valid && i_idEx.ctrl.memRead && hits(i_idEx.dest, srcRs, srcRt);
    assign exBlock  = isBranch && i_idEx.ctrl.regWrite && hits(i_idEx.dest, srcRs, srcRt);
    // no MEM to ID path, so the compare waits for any pending MEM write
    assign memBlock = isBranch && i_exMem.ctrl.regWrite && hits(i_exMem.dest, srcRs, srcRt);

    assign o_stall = loadUse || exBlock || memBlock;
    assign o_fwdA  = pickFwd(i_idEx.rs, i_exMem, i_wbDest, i_wbWrite);
    assign o_fwdB  = pickFwd(i_idEx.rt, i_exMem, i_wbDest, i_wbWrite);

endmodule

// ==== src/mipsCore.sv ====
module mipsCore
    import mipsPkg::*;
#(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic                 clk,
    input  logic                 i_rstN,
    input  logic                 i_halt,
    input  logic                 i_imemWe,
    input  logic [dataWidth-1:0] i_imemAddr,
    input  logic [dataWidth-1:0] i_imemData,
    input  regAddrT              i_dbgRegAddr,
    input  logic [dataWidth-1:0] i_dbgMemAddr,
    output logic [dataWidth-1:0] o_dbgRegData,
    output logic [dataWidth-1:0] o_dbgMemData,
    output logic                 o_end
);

    ifIdT                 ifId;
    idExT                 idEx;
    exMemT                exMem;
    wbT                   wb;
    logic                 redirect;
    logic [dataWidth-1:0] target;
    logic                 haltSeen;
    logic                 stall;
    fwdSelE               fwdA;
    fwdSelE               fwdB;

    ifStage #(
        .imemDepth (imemDepth)
    ) u_if (
        .clk        (clk),
        .i_rstN     (i_rstN),
        .i_halt     (i_halt),
        .i_stall    (stall),
        .i_haltSeen (haltSeen),
        .i_imemWe   (i_imemWe),
        .i_imemAddr (i_imemAddr),
        .i_imemData (i_imemData),
        .i_redirect (redirect),
        .i_target   (target),
        .o_ifId     (ifId)
    );

    idStage u_id (
        .clk          (clk),
        .i_rstN       (i_rstN),
        .i_halt       (i_halt),
        .i_stall      (stall),
        .i_ifId       (ifId),
        .i_wb         (wb),
        .i_dbgRegAddr (i_dbgRegAddr),
        .o_idEx       (idEx),
        .o_redirect   (redirect),
        .o_target     (target),
        .o_haltSeen   (haltSeen),
        .o_dbgRegData (o_dbgRegData)
    );

    hazardUnit u_hazard (
        .i_ifId    (ifId),
        .i_idEx    (idEx),
        .i_exMem   (exMem),
        .i_wbDest  (wb.dest),
        .i_wbWrite (wb.we),
        .o_stall   (stall),
        .o_fwdA    (fwdA),
        .o_fwdB    (fwdB)
    );

    exStage u_ex (
        .clk      (clk),
        .i_rstN   (i_rstN),
        .i_halt   (i_halt),
        .i_idEx   (idEx),
        .i_fwdA   (fwdA),
        .i_fwdB   (fwdB),
        .i_memFwd (exMem.aluResult),
        .i_wb     (wb),
        .o_exMem  (exMem)
    );

    memStage #(
        .dmemDepth (dmemDepth)
    ) u_mem (
        .clk          (clk),
        .i_rstN       (i_rstN),
        .i_halt       (i_halt),
        .i_exMem      (exMem),
        .i_dbgMemAddr (i_dbgMemAddr),
        .o_wb         (wb),
        .o_dbgMemData (o_dbgMemData),
        .o_end        (o_end)
    );

endmodule

// ==== dv/tbMips.sv ====
module tbMips
    import mipsPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;

    logic                 clk;
    logic                 rstN;
    logic                 coreHalt;
    logic                 imemWe;
    logic [dataWidth-1:0] imemAddr;
    logic [dataWidth-1:0] imemData;
    regAddrT              dbgRegAddr;
    logic [dataWidth-1:0] dbgMemAddr;
    logic [dataWidth-1:0] dbgRegData;
    logic [dataWidth-1:0] dbgMemData;
    logic                 coreEnd;

    logic [31:0] prog [$];  // word 0 first
    int          budgetCycles = 0;
    int          lastRunCycles = 0;

    mipsCore #(
        .imemDepth (imemDepth),
        .dmemDepth (dmemDepth)
    ) dut (
        .clk          (clk),
        .i_rstN       (rstN),
        .i_halt       (coreHalt),
        .i_imemWe     (imemWe),
        .i_imemAddr   (imemAddr),
        .i_imemData   (imemData),
        .i_dbgRegAddr (dbgRegAddr),
        .i_dbgMemAddr (dbgMemAddr),
        .o_dbgRegData (dbgRegData),
        .o_dbgMemData (dbgMemData),
        .o_end        (coreEnd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rType(funcE fn, int rd, int rs, int rt, int shamt = 0);
        return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
    endfunction

    function automatic logic [31:0] iType(opcodeE op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jType(int wordIdx);
        return {opJ, 26'(wordIdx)};
    endfunction

    function automatic logic [31:0] haltInstr();
        return {opHalt, 26'd0};
    endfunction

    function automatic logic [31:0] signExt(int imm);
        logic [15:0] v;
        v = 16'(imm);
        return {{16{v[15]}}, v};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkEq(string testName, string what, logic [31:0] want, logic [31:0] got);
        assert (got === want) else begin
            $display("mismatch %s %s: expected %h, actual %h", testName, what, want, got);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic readReg(int r, output logic [31:0] val);
        nextCycle();
        dbgRegAddr = regAddrWidth'(r);
        #5;
        val = dbgRegData;
    endtask

    task automatic expectReg(string testName, int r, logic [31:0] want);
        logic [31:0] got;
        readReg(r, got);
        checkEq(testName, $sformatf("r%0d", r), want, got);
    endtask

    task automatic expectMem(string testName, int wordAddr, logic [31:0] want);
        nextCycle();
        dbgMemAddr = 32'(wordAddr);
        #5;
        checkEq(testName, $sformatf("mem[%0d]", wordAddr), want, dbgMemData);
    endtask

    // load prog, reset, run to o_end; optional freeze window mid-run
    task automatic loadAndRun(string testName, int freezeAt = 0, int freezeLen = 0);
        int cycles;
        budgetCycles += 4 * prog.size() + 50 + freezeLen;
        nextCycle();
        coreHalt = 1'b1;
        foreach (prog[i]) begin
            imemWe   = 1'b1;
            imemAddr = 32'(i);
            imemData = prog[i];
            nextCycle();
        end
        imemWe = 1'b0;
        rstN   = 1'b0;
        repeat (16) nextCycle();
        rstN = 1'b1;
        nextCycle();
        coreHalt = 1'b0;
        cycles   = 0;
        while (!coreEnd) begin
            nextCycle();
            cycles++;
            if (cycles == freezeAt) begin
                coreHalt = 1'b1;
                repeat (freezeLen) begin
                    nextCycle();
                    checkEq(testName, "o_end while frozen", 32'd0, {31'd0, coreEnd});
                end
                coreHalt = 1'b0;
            end
        end
        lastRunCycles = cycles;
    endtask

    task automatic forwardChain();
        logic [31:0] want [9];
        prog.delete();
        prog.push_back(iType(opAddiu, 1, 0, 16'h7abc));
        prog.push_back(iType(opAddiu, 2, 1, -16'sh1234));
        prog.push_back(rType(fnAddu, 3, 2, 1));
        prog.push_back(rType(fnSubu, 4, 3, 2));
        prog.push_back(rType(fnAnd, 5, 4, 3));
        prog.push_back(rType(fnOr, 6, 5, 2));
        prog.push_back(rType(fnXor, 7, 6, 4));
        prog.push_back(iType(opAddiu, 0, 7, 1));  // r0 must ignore this
        prog.push_back(rType(fnAddu, 8, 0, 7));
        prog.push_back(haltInstr());
        want[0] = 32'd0;
        want[1] = 32'h0000_7abc;
        want[2] = want[1] + 32'hffff_edcc;
        want[3] = want[2] + want[1];
        want[4] = want[3] - want[2];
        want[5] = want[4] & want[3];
        want[6] = want[5] | want[2];
        want[7] = want[6] ^ want[4];
        want[8] = want[7];
        loadAndRun("forwardChain");
        for (int r = 0; r < 9; r++) begin
            expectReg("forwardChain", r, want[r]);
        end
    endtask

    task automatic storeLoad();
        logic [31:0] sum;
        prog.delete();
        prog.push_back(iType(opAddiu, 9, 0, 8));
        prog.push_back(iType(opAddiu, 1, 0, 16'h55));
        prog.push_back(iType(opAddiu, 2, 0, 16'h7ff0));
        prog.push_back(rType(fnAddu, 3, 1, 2));
        prog.push_back(iType(opSw, 3, 9, 0));    // word 2
        prog.push_back(iType(opSw, 1, 9, 4));    // word 3
        prog.push_back(iType(opLw, 4, 9, 0));
        prog.push_back(rType(fnAddu, 5, 4, 1));  // load-use
        prog.push_back(iType(opLw, 6, 9, 4));
        prog.push_back(iType(opSw, 6, 9, 8));    // loaded value as store data
        prog.push_back(iType(opLw, 7, 9, 8));
        prog.push_back(haltInstr());
        sum = 32'h55 + 32'h7ff0;
        loadAndRun("storeLoad");
        expectMem("storeLoad", 2, sum);
        expectMem("storeLoad", 3, 32'h55);
        expectMem("storeLoad", 4, 32'h55);
        expectReg("storeLoad", 3, sum);
        expectReg("storeLoad", 4, sum);
        expectReg("storeLoad", 5, sum + 32'h55);
        expectReg("storeLoad", 6, 32'h55);
        expectReg("storeLoad", 7, 32'h55);
    endtask

    task automatic controlFlow();
        prog.delete();
        prog.push_back(iType(opAddiu, 1, 0, 5));
        prog.push_back(iType(opAddiu, 2, 0, 5));
        prog.push_back(iType(opBeq, 2, 1, 1));        // taken, to word 4
        prog.push_back(iType(opAddiu, 10, 0, 16'hbad));
        prog.push_back(iType(opAddiu, 3, 0, 16'h11));
        prog.push_back(iType(opBne, 2, 1, 1));        // not taken
        prog.push_back(iType(opAddiu, 4, 0, 16'h22));
        prog.push_back(iType(opBne, 3, 1, 1));        // taken, to word 9
        prog.push_back(iType(opAddiu, 11, 0, 16'hbad));
        prog.push_back(jType(11));
        prog.push_back(iType(opAddiu, 12, 0, 16'hbad));
        prog.push_back(iType(opAddiu, 5, 0, 16'h33));
        prog.push_back(haltInstr());
        loadAndRun("controlFlow");
        expectReg("controlFlow", 3, 32'h11);
        expectReg("controlFlow", 4, 32'h22);
        expectReg("controlFlow", 5, 32'h33);
        expectReg("controlFlow", 10, 32'd0);
        expectReg("controlFlow", 11, 32'd0);
        expectReg("controlFlow", 12, 32'd0);
    endtask

    task automatic luiShiftSlt();
        logic [31:0] upper;
        logic [31:0] neg;
        prog.delete();
        prog.push_back(iType(opLui, 1, 0, 16'h8765));
        prog.push_back(iType(opOri, 1, 1, 16'h4321));
        prog.push_back(rType(fnSll, 2, 0, 1, 4));
        prog.push_back(rType(fnSrl, 3, 0, 1, 8));
        prog.push_back(iType(opAddiu, 4, 0, -3));
        prog.push_back(iType(opAddiu, 5, 0, 2));
        prog.push_back(rType(fnSlt, 6, 4, 5));   // -3 < 2
        prog.push_back(rType(fnSlt, 7, 5, 4));
        prog.push_back(rType(fnSlt, 8, 1, 0));   // negative r1 < 0
        prog.push_back(iType(opAndi, 9, 4, 16'hff0f));
        prog.push_back(haltInstr());
        upper = {16'h8765, 16'h0000} | 32'h0000_4321;
        neg   = 32'hffff_fffd;
        loadAndRun("luiShiftSlt");
        expectReg("luiShiftSlt", 1, upper);
        expectReg("luiShiftSlt", 2, upper << 4);
        expectReg("luiShiftSlt", 3, upper >> 8);
        expectReg("luiShiftSlt", 4, neg);
        expectReg("luiShiftSlt", 6, 32'd1);
        expectReg("luiShiftSlt", 7, 32'd0);
        expectReg("luiShiftSlt", 8, 32'd1);  // sign bit of r1 is set
        expectReg("luiShiftSlt", 9, neg & 32'h0000_ff0f);
    endtask

    task automatic randomAlu();
        logic [31:0] model [8];
        int          op;
        int          rd;
        int          rs;
        int          rt;
        int          imm;
        prog.delete();
        model[0] = '0;
        for (int r = 1; r < 8; r++) begin
            imm = $urandom_range(16'hffff);
            prog.push_back(iType(opAddiu, r, 0, imm));
            model[r] = signExt(imm);
        end
        repeat (33) begin
            op = $urandom_range(3);
            rd = $urandom_range(7, 1);
            rs = $urandom_range(7, 1);
            rt = $urandom_range(7, 1);
            case (op)
                0: begin
                    prog.push_back(rType(fnAddu, rd, rs, rt));
                    model[rd] = model[rs] + model[rt];
                end
                1: begin
                    prog.push_back(rType(fnSubu, rd, rs, rt));
                    model[rd] = model[rs] - model[rt];
                end
                2: begin
                    prog.push_back(rType(fnXor, rd, rs, rt));
                    model[rd] = model[rs] ^ model[rt];
                end
                default: begin
                    imm = $urandom_range(16'hffff);
                    prog.push_back(iType(opAddiu, rd, rs, imm));
                    model[rd] = model[rs] + signExt(imm);
                end
            endcase
        end
        prog.push_back(haltInstr());
        loadAndRun("randomAlu");
        for (int r = 1; r < 8; r++) begin
            expectReg("randomAlu", r, model[r]);
        end
    endtask

    task automatic haltFreeze();
        logic [31:0] want [8];
        int          freeCycles;
        prog.delete();
        prog.push_back(iType(opAddiu, 1, 0, 5));
        prog.push_back(rType(fnAddu, 2, 2, 1));   // loop: r2 += r1
        prog.push_back(iType(opAddiu, 1, 1, -1));
        prog.push_back(iType(opBne, 0, 1, -3));
        prog.push_back(iType(opSw, 2, 0, 0));
        prog.push_back(iType(opLw, 3, 0, 0));
        prog.push_back(rType(fnAddu, 4, 3, 3));
        prog.push_back(rType(fnXor, 5, 4, 2));
        prog.push_back(haltInstr());
        want[0] = 32'd0;
        want[1] = 32'd0;
        want[2] = 32'd15;  // 5 + 4 + 3 + 2 + 1
        want[3] = 32'd15;
        want[4] = 32'd30;
        want[5] = 32'd30 ^ 32'd15;
        want[6] = 32'd0;
        want[7] = 32'd0;
        loadAndRun("haltFreeze");
        freeCycles = lastRunCycles;
        for (int r = 1; r < 8; r++) begin
            expectReg("haltFreeze", r, want[r]);
        end
        expectMem("haltFreeze", 0, 32'd15);
        loadAndRun("haltFreeze", 6, freeCycles);  // window covers the free-run end
        for (int r = 1; r < 8; r++) begin
            expectReg("haltFreeze", r, want[r]);
        end
    endtask

    initial begin : watchdog
        int elapsed;
        elapsed = 0;
        while (elapsed <= budgetCycles) begin
            @(posedge clk);
            elapsed++;
        end
        $display("o_end never rose");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        rstN       = 1'b0;
        coreHalt   = 1'b1;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        dbgRegAddr = '0;
        dbgMemAddr = '0;
        void'($urandom(32'h3c00_bc3f));
        forwardChain();
        storeLoad();
        controlFlow();
        luiShiftSlt();
        randomAlu();
        haltFreeze();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/mipsPkg.sv
src/ifStage.sv
src/idStage.sv
src/exStage.sv
src/memStage.sv
src/hazardUnit.sv
src/mipsCore.sv
dv/tbMips.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - files:
      - src/mipsPkg.sv
      - src/ifStage.sv
      - src/idStage.sv
      - src/exStage.sv
      - src/memStage.sv
      - src/hazardUnit.sv
      - src/mipsCore.sv
  - target: test
    files:
      - dv/tbMips.sv
